/* flist.f */
+incdir+test
src/ras_pkg.sv
src/ras_ram.sv
src/ras_ptr.sv
src/ras_link.sv
src/ras_merge.sv
src/ras_top.sv
test/tb_ras.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ras
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Regression failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/ras_model.svh */
`ifndef RAS_MODEL_SVH
`define RAS_MODEL_SVH

ras_addr_t stk [THREADS][DEPTH];  // expected contents, one circular stack per thread
int        free_slot [THREADS];
ras_pred_t exp_q [$];             // in the order the returns were sent
int        errors;
int        checks;

function automatic ras_addr_t link_target(input ras_addr_t pc, input logic [LNK_W-1:0] lnk,
                                          input logic trace);
  logic [LNK_W-5:0] lhi;
  logic [PC_W-5:0]  step;
  lhi = lnk[LNK_W-1:4];
  if (trace) begin
    step = {{(PC_W - LNK_W){lhi[LNK_W-5]}}, lhi};  // signed link bits 15..4
  end else begin
    step = {{(PC_W - 5){1'b0}}, lnk[4]};
  end
  return {pc[PC_W-1:4] + step, lnk[3:0]};
endfunction

task automatic remember_call(input logic [THR_W-1:0] thr, input ras_addr_t addr);
  stk[thr][free_slot[thr]] = addr;
  free_slot[thr] = (free_slot[thr] + 1) % DEPTH;  // overflow drops the oldest
endtask

task automatic predict_return(input logic [THR_W-1:0] thr);
  ras_pred_t p;
  free_slot[thr] = (free_slot[thr] + DEPTH - 1) % DEPTH;
  p.thread = thr;
  p.target = stk[thr][free_slot[thr]];
  exp_q.push_back(p);
endtask

task automatic clear_stack(input logic [THR_W-1:0] thr);
  free_slot[thr] = 0;
endtask

task automatic check_pred(input ras_pred_t got, input ras_pred_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAIL %0t ns: prediction thread %0d target %h, expected thread %0d target %h",
             $time, got.thread, got.target, exp.thread, exp.target);
  end
endtask

task automatic check_credit(input int got, input int exp, input string what);
  checks++;
  if (got != exp) begin
    errors++;
    $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

`endif

/* test/tb_ras.sv */
`timescale 1ns/1ns

module tb_ras;
  import ras_pkg::*;

  localparam int DEPTH       = 16;
  localparam int PRED_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;

  typedef struct packed {
    int               test;
    ras_op_t          op;
    logic             flush;
    logic [THR_W-1:0] fthr;
    logic             hold;  // consumer keeps its output credits
  } entry_t;

  logic             clk;
  logic             rst;
  ras_op_t          op;
  logic             flush;
  logic [THR_W-1:0] flush_thread;
  logic             out_credit;
  logic             pred_valid;
  ras_pred_t        pred;
  logic             ret_credit;

  entry_t tbl [$];
  string  names [1:6];
  int     pending [$];  // cycles at which consumed credits go back
  int     idx;
  int     cur;
  bit     taken;
  integer seed;
  int     limit;
  int     cycles;
  int     up_cred;
  int     cons_cred;
  int     t_rc;
  int     t_rets;
  int     held;
  int     t_err0;

  `include "ras_model.svh"

  ras_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .flush        (flush),
    .flush_thread (flush_thread),
    .out_credit   (out_credit),
    .pred_valid   (pred_valid),
    .pred         (pred),
    .ret_credit   (ret_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic put(input int t, input ras_kind_t k, input logic [THR_W-1:0] thr,
                     input ras_addr_t pc, input logic [LNK_W-1:0] lnk, input logic tr,
                     input logic fl, input logic [THR_W-1:0] fthr, input logic hold);
    entry_t e;
    e.test     = t;
    e.op.kind  = k;
    e.op.thread = thr;
    e.op.pc    = pc;
    e.op.lnk   = lnk;
    e.op.trace = tr;
    e.flush    = fl;
    e.fthr     = fthr;
    e.hold     = hold;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    put(1, RAS_CALL, 1'b0, 47'h0000_1000_0040, 16'h0004, 1'b0, 1'b0, 1'b0, 1'b0);
    put(1, RAS_CALL, 1'b0, 47'h0000_1000_0ff0, 16'h0019, 1'b0, 1'b0, 1'b0, 1'b0);
    put(1, RAS_CALL, 1'b0, 47'h7fff_ffff_fff0, 16'h0013, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      put(1, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    put(2, RAS_CALL, 1'b1, 47'h0123_4567_89a0, 16'hf003, 1'b1, 1'b0, 1'b0, 1'b0);  // negative
    put(2, RAS_CALL, 1'b1, 47'h0123_4567_89a0, 16'h7ff5, 1'b1, 1'b0, 1'b0, 1'b0);
    put(2, RAS_CALL, 1'b1, 47'h0000_0000_0010, 16'h801c, 1'b1, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      put(2, RAS_RET, 1'b1, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    put(3, RAS_CALL, 1'b1, 47'h0000_0300_0100, 16'h0021, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_CALL, 1'b0, 47'h0000_0300_0200, 16'h0032, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_RET, 1'b1, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);  // other thread so no bypass
    put(3, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_CALL, 1'b0, 47'h0000_0300_0300, 16'h0047, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_CALL, 1'b0, 47'h0000_0300_0400, 16'h0058, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_CALL, 1'b0, 47'h0000_0300_0500, 16'hfe19, 1'b1, 1'b0, 1'b0, 1'b0);
    put(3, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(3, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      put(4, RAS_CALL, 1'b0, 47'h0000_4000_0000 + 47'(i * 32), 16'(i), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    put(4, RAS_CALL, 1'b1, 47'h0000_4100_0000, 16'h0011, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_CALL, 1'b1, 47'h0000_4100_0040, 16'h0022, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_RET, 1'b1, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_CALL, 1'b1, 47'h0000_4100_0080, 16'h0033, 1'b0, 1'b1, 1'b0, 1'b0);  // flush t0
    put(4, RAS_RET, 1'b1, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_RET, 1'b1, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_CALL, 1'b0, 47'h0000_4200_0000, 16'h0044, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_CALL, 1'b0, 47'h0000_4200_0040, 16'h0055, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    put(4, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      put(5, RAS_CALL, 1'b0, 47'h0000_5000_0000 + 47'(i * 16), 16'(i * 7), 1'b0, 1'b0, 1'b0, 1'b1);
    end
    for (int i = 0; i < 10; i++) begin
      put(5, (i < 4) ? RAS_RET : RAS_NONE, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
    end
    for (int i = 0; i < DEPTH + 4; i++) begin
      put(6, RAS_CALL, 1'b0, 47'h0000_2000_0000 + 47'(i * 64), 16'(i * 19), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < DEPTH; i++) begin
      put(6, RAS_RET, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic observe(input logic hold);
    if (ret_credit) begin
      up_cred++;
      t_rc++;
    end
    if (pred_valid) begin
      if (hold) begin
        held++;
      end
      if (cons_cred == 0) begin
        errors++;
        $display("prediction raised with no output credit at %0t ns", $time);
      end else begin
        cons_cred--;
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("prediction at %0t ns with no return outstanding", $time);
      end else begin
        check_pred(pred, exp_q.pop_front());
      end
      pending.push_back(cycles + 1 + int'({$random(seed)} % 4));
    end
  endtask

  // drives one clock of stimulus and idles a return that has no credit
  task automatic cycle(input entry_t e, output bit ok);
    ras_op_t o;
    logic    blocked;
    @(negedge clk);
    observe(e.hold);
    o = e.op;
    ok = !(o.kind == RAS_RET && up_cred == 0);
    if (!ok) begin
      o = '0;
    end
    blocked = e.flush && ok && (e.fthr == o.thread);
    if (e.flush && ok) begin
      clear_stack(e.fthr);
    end
    if (o.kind == RAS_CALL && !blocked) begin
      remember_call(o.thread, link_target(o.pc, o.lnk, o.trace));
    end
    if (o.kind == RAS_RET && !blocked) begin
      predict_return(o.thread);
      up_cred--;
      t_rets++;
    end
    op = o;
    flush = e.flush && ok;
    flush_thread = e.fthr;
    out_credit = 1'b0;
    if (!e.hold && pending.size() != 0 && pending[0] <= cycles) begin
      void'(pending.pop_front());
      out_credit = 1'b1;
      cons_cred++;
    end
  endtask

  task automatic finish_test(input int t);
    entry_t idle;
    bit     ok;
    idle = '0;
    while (exp_q.size() != 0 || pending.size() != 0) begin
      cycle(idle, ok);
    end
    if (t == 5) begin
      check_credit(held, OUT_CREDITS, "predictions while credits were held");
    end
    check_credit(t_rc, t_rets, "ret_credit pulses");
    $display("test %0d %s: %0d errors", t, names[t], errors - t_err0);
    t_rc = 0;
    t_rets = 0;
    held = 0;
    t_err0 = errors;
  endtask

  initial begin
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", limit);
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    op = '0;
    flush = 1'b0;
    flush_thread = '0;
    out_credit = 1'b0;
    seed = 9;
    up_cred = PRED_DEPTH;
    cons_cred = OUT_CREDITS;
    names[1] = "lifo normal mode";
    names[2] = "trace mode link";
    names[3] = "call then return bypass";
    names[4] = "threads and flush";
    names[5] = "output back-pressure";
    names[6] = "stack wrap";
    build_table();
    limit = tbl.size() * 8 + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idx = 0;
    cur = tbl[0].test;
    while (idx < tbl.size()) begin
      if (tbl[idx].test != cur) begin
        finish_test(cur);
        cur = tbl[idx].test;
      end
      cycle(tbl[idx], taken);
      if (taken) begin
        idx++;
      end
    end
    finish_test(cur);
    $display("tests %0d, checks %0d, errors %0d", cur, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* src/ras_top.sv */
`timescale 1ns/1ns

module ras_top #(
  parameter int DEPTH       = 16,
  parameter int PRED_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  ras_pkg::ras_op_t          op,
  input  logic                      flush,
  input  logic [ras_pkg::THR_W-1:0] flush_thread,
  input  logic                      out_credit,
  output logic                      pred_valid,
  output ras_pkg::ras_pred_t        pred,
  output logic                      ret_credit
);
  import ras_pkg::*;

  ras_wr_t   wr;       // push from the link calculator
  ras_addr_t rd_data;  // popped entry, one cycle after the return

  ras_ptr #(
    .DEPTH(DEPTH)
  ) i_ptr (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .flush        (flush),
    .flush_thread (flush_thread),
    .wr           (wr),
    .rd_data      (rd_data)
  );

  ras_link i_link (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .flush        (flush),
    .flush_thread (flush_thread),
    .wr           (wr)
  );

  ras_merge #(
    .PRED_DEPTH  (PRED_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_merge (
    .clk        (clk),
    .rst        (rst),
    .op         (op),
    .wr         (wr),
    .rd_data    (rd_data),
    .out_credit (out_credit),
    .pred_valid (pred_valid),
    .pred       (pred),
    .ret_credit (ret_credit)
  );

endmodule

/* src/ras_merge.sv */
`timescale 1ns/1ns

module ras_merge #(
  parameter int PRED_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  ras_pkg::ras_op_t   op,
  input  ras_pkg::ras_wr_t   wr,
  input  ras_pkg::ras_addr_t rd_data,
  input  logic               out_credit,
  output logic               pred_valid,
  output ras_pkg::ras_pred_t pred,
  output logic               ret_credit
);
  import ras_pkg::*;

  localparam int QW = $clog2(PRED_DEPTH);
  localparam int CW = $clog2(PRED_DEPTH + 1);
  localparam int KW = $clog2(OUT_CREDITS + 1);

  logic             ret_q;
  logic [THR_W-1:0] thr_q;
  logic             byp_q;
  ras_addr_t        byp_data_q;
  ras_pred_t        fresh;
  ras_pred_t        queue [PRED_DEPTH];
  logic [QW-1:0]    head;
  logic [QW-1:0]    tail;
  logic [CW-1:0]    count;
  logic [KW-1:0]    cred;
  logic             fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_q <= 1'b0;
    end else begin
      ret_q <= (op.kind == RAS_RET);
    end
  end

  // return right after a call on the same thread takes the fresh link
  always_ff @(posedge clk) begin
    if (op.kind == RAS_RET) begin
      thr_q      <= op.thread;
      byp_q      <= wr.wen && (wr.thread == op.thread);
      byp_data_q <= wr.data;
    end
  end

  assign fresh.thread = thr_q;
  assign fresh.target = byp_q ? byp_data_q : rd_data;

  always_ff @(posedge clk) begin
    if (ret_q) begin
      queue[tail] <= fresh;
    end
  end

  assign fire       = (count != '0) && (cred != '0);
  assign pred_valid = fire;
  assign pred       = queue[head];
  assign ret_credit = fire;  // one upstream credit per delivered prediction

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      cred  <= KW'(OUT_CREDITS);
    end else begin
      if (ret_q) begin
        tail <= (tail == QW'(PRED_DEPTH - 1)) ? '0 : tail + QW'(1);
      end
      if (fire) begin
        head <= (head == QW'(PRED_DEPTH - 1)) ? '0 : head + QW'(1);
      end
      case ({ret_q, fire})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
      case ({fire, out_credit})
        2'b10:   cred <= cred - KW'(1);
        2'b01:   cred <= cred + KW'(1);
        default: cred <= cred;
      endcase
    end
  end

  // upstream return credits keep the queue from filling
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    ret_q && !fire |-> count < CW'(PRED_DEPTH));

  // consumer only returns credits it was given
  a_cred_max: assert property (@(posedge clk) disable iff (rst)
    out_credit |-> fire || cred < KW'(OUT_CREDITS));

endmodule

/* src/ras_link.sv */
`timescale 1ns/1ns

module ras_link (
  input  logic                      clk,
  input  logic                      rst,
  input  ras_pkg::ras_op_t          op,
  input  logic                      flush,
  input  logic [ras_pkg::THR_W-1:0] flush_thread,
  output ras_pkg::ras_wr_t          wr
);
  import ras_pkg::*;

  localparam int HI_W = PC_W - 4;
  localparam int LK_W = LNK_W - 4;

  logic             call_q;
  logic [THR_W-1:0] thr_q;
  logic [PC_W-1:0]  pc_q;
  logic [LNK_W-1:0] lnk_q;
  logic             trace_q;
  logic [HI_W-1:0]  offset;
  logic [HI_W-1:0]  hi;

  always_ff @(posedge clk) begin
    if (rst) begin
      call_q <= 1'b0;
    end else begin
      call_q <= (op.kind == RAS_CALL) && !(flush && flush_thread == op.thread);
    end
  end

  always_ff @(posedge clk) begin
    if (op.kind == RAS_CALL) begin
      thr_q   <= op.thread;
      pc_q    <= op.pc;
      lnk_q   <= op.lnk;
      trace_q <= op.trace;
    end
  end

  // trace adds the signed link, normal mode only carries link bit 4
  assign offset = trace_q ? {{(HI_W - LK_W){lnk_q[LNK_W-1]}}, lnk_q[LNK_W-1:4]}
                          : {{(HI_W - 1){1'b0}}, lnk_q[4]};
  assign hi     = pc_q[PC_W-1:4] + offset;

  assign wr.wen    = call_q && !(flush && flush_thread == thr_q);  // flush cancels the push
  assign wr.thread = thr_q;
  assign wr.data   = {hi, lnk_q[3:0]};

endmodule

/* src/ras_ptr.sv */
`timescale 1ns/1ns

module ras_ptr #(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  ras_pkg::ras_op_t         op,
  input  logic                     flush,
  input  logic [ras_pkg::THR_W-1:0] flush_thread,
  input  ras_pkg::ras_wr_t         wr,
  output ras_pkg::ras_addr_t       rd_data
);
  import ras_pkg::*;

  localparam int IW = $clog2(DEPTH);

  logic [IW-1:0] rd_ptr [THREADS];
  logic [IW-1:0] wr_ptr [THREADS];
  logic [IW-1:0] wr_slot;  // slot of the last push, used by the delayed write
  logic          blocked;
  logic          push;
  logic          pop;

  assign blocked = flush && (flush_thread == op.thread);  // same-thread op is dropped
  assign push    = (op.kind == RAS_CALL) && !blocked;
  assign pop     = (op.kind == RAS_RET) && !blocked;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < THREADS; t++) begin
        rd_ptr[t] <= IW'(DEPTH - 1);
        wr_ptr[t] <= '0;
      end
    end else begin
      if (flush) begin
        rd_ptr[flush_thread] <= IW'(DEPTH - 1);
        wr_ptr[flush_thread] <= '0;
      end
      if (push) begin
        rd_ptr[op.thread] <= rd_ptr[op.thread] + IW'(1);  // wraps over the oldest entry
        wr_ptr[op.thread] <= wr_ptr[op.thread] + IW'(1);
      end else if (pop) begin
        rd_ptr[op.thread] <= rd_ptr[op.thread] - IW'(1);
        wr_ptr[op.thread] <= wr_ptr[op.thread] - IW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      wr_slot <= wr_ptr[op.thread];
    end
  end

  ras_ram #(
    .DEPTH(DEPTH)
  ) i_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (pop),
    .rd_addr ({op.thread, rd_ptr[op.thread]}),
    .rd_data (rd_data),
    .wr_addr (wr_slot),
    .wr      (wr)
  );

  // an unknown thread would reset the wrong stack
  a_flush_thread_known: assert property (@(posedge clk) disable iff (rst)
    flush |-> !$isunknown(flush_thread));

endmodule

/* src/ras_ram.sv */
`timescale 1ns/1ns

module ras_ram #(
  parameter int DEPTH = 16,
  localparam int IW = $clog2(DEPTH),
  localparam int AW = ras_pkg::THR_W + IW
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rd_en,
  input  logic [AW-1:0]      rd_addr,
  output ras_pkg::ras_addr_t rd_data,
  input  logic [IW-1:0]      wr_addr,
  input  ras_pkg::ras_wr_t   wr
);
  import ras_pkg::*;

  ras_addr_t     mem [THREADS*DEPTH];
  logic [AW-1:0] rd_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[{wr.thread, wr_addr}] <= wr.data;  // thread selects the half
    end
  end

  // a write in the cycle before is already visible here
  assign rd_data = mem[rd_addr_q];

endmodule

/* src/ras_pkg.sv */
package ras_pkg;

  localparam int THREADS = 2;
  localparam int THR_W   = $clog2(THREADS);
  localparam int PC_W    = 47;
  localparam int LNK_W   = 16;

  typedef enum logic [1:0] {
    RAS_NONE = 2'd0,
    RAS_CALL = 2'd1,
    RAS_RET  = 2'd2
  } ras_kind_t;

  typedef logic [PC_W-1:0] ras_addr_t;

  // one branch decoder operation per cycle
  typedef struct packed {
    ras_kind_t              kind;
    logic [THR_W-1:0]       thread;
    logic [PC_W-1:0]        pc;     // fetch pc of the call
    logic [LNK_W-1:0]       lnk;
    logic                   trace;  // selects the sign-extended link rule
  } ras_op_t;

  typedef struct packed {
    logic [THR_W-1:0]       thread;
    ras_addr_t              target;
  } ras_pred_t;

  // registered push, one cycle behind the call
  typedef struct packed {
    logic                   wen;
    logic [THR_W-1:0]       thread;
    ras_addr_t              data;
  } ras_wr_t;

endpackage
